/* Makefile */
SIM      := verilator
FLAGS    := --binary --timing --assert -j 0
TOP      := cpu_ctrl_tb
FILELIST := compile.f
OBJ_DIR  := obj_dir
LOG      := sim.log
FAIL_MSG := Errors found
PASS_MSG := No errors

SRCS := $(filter-out +%,$(shell cat $(FILELIST))) $(wildcard verilog/*.svh)
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

# rebuilt only when a source, a header or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "simulation ended early"; exit 1; fi
	@echo "simulation passed"

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* compile.f */
+incdir+verilog
verilog/cpu_ctrl_pkg.sv
verilog/phaser.sv
verilog/instruction_register.sv
verilog/program_counter.sv
verilog/address_selector.sv
verilog/cpu_ctrl_top.sv
test/cpu_ctrl_tb.sv

/* test/cpu_ctrl_golden.txt */
// columns: instruction word, mar value loaded during fetch, expected address during decode
// bit 23 low expects the mar value, bit 23 high the low 16 instruction bits
030245 1234 1234
2A00FF 00A0 00A0
4F1234 BEEF BEEF
7F0000 5555 5555
80ABCD 0F0F ABCD
A11000 2222 1000
C2FFFF 3333 FFFF
FFFFFF 4444 FFFF
000000 0000 0000
1F8001 FFFF FFFF
9E0010 7777 0010
3CA5A5 8001 8001
E00001 0002 0001
55C3C3 C3C3 C3C3
B81234 4321 1234
6E5A5A 0100 0100

/* test/cpu_ctrl_tb.sv */
`timescale 1ns/1ps
`include "cpu_ctrl_macros.svh"

module cpu_ctrl_tb;

    localparam int max_golden   = 32;  // lines the golden file may hold
    localparam int n_random     = 12;  // random instructions after the golden ones
    localparam int reset_cycles = 10;
    localparam int mem_depth    = 1 << `CPU_ADDR_W;

    logic                                 clk;
    logic                                 rst_n;
    logic [`CPU_INSTR_W-1:0]              rom_data = '0;
    logic                                 mar_load = 1'b0;
    logic [`CPU_ADDR_W-1:0]               mar_in   = '0;
    logic [`CPU_ADDR_W-1:0]               addr;
    logic [`CPU_SEQ_W-1:0]                seq;
    cpu_ctrl_pkg::phase_e                 phase;
    cpu_ctrl_pkg::opcode_e                opcode;
    logic [`CPU_TARG_HI-`CPU_TARG_LO:0]   target;
    logic [`CPU_LBUS_HI-`CPU_LBUS_LO:0]   lbus_sel;
    logic [`CPU_RBUS_HI-`CPU_RBUS_LO:0]   rbus_sel;
    logic [`CPU_ALUOP_HI-`CPU_ALUOP_LO:0] alu_op;
    logic                                 illegal_op;
    logic [`CPU_ADDR_W-1:0]               pc;

    // golden file, three words per line: instruction, mar value, expected decode address
    logic [`CPU_INSTR_W-1:0] golden_mem [0:3*max_golden-1];
    logic [`CPU_INSTR_W-1:0] rom [0:mem_depth-1];      // program image, indexed by addr
    logic [`CPU_ADDR_W-1:0]  prog_mar [0:mem_depth-1]; // mar value per pc
    logic [`CPU_ADDR_W-1:0]  prog_exp [0:mem_depth-1]; // expected decode addr per pc

    int     n_golden;
    int     n_instr;
    logic   program_ready = 1'b0;
    integer seed = 21604;
    int     mismatch_count = 0;
    int     other_errors = 0;
    int     done_count = 0;   // instructions completed since reset

    // model of the control state in the cycle that is ending
    logic                    model_valid = 1'b0;
    int                      cnt_m;
    logic [`CPU_ADDR_W-1:0]  pc_m;
    logic [`CPU_ADDR_W-1:0]  mar_m;
    logic [`CPU_INSTR_W-1:0] ir_m;

    cpu_ctrl_top dut0 (
        .clk        (clk),
        .rst_n      (rst_n),
        .rom_data   (rom_data),
        .mar_load   (mar_load),
        .mar_in     (mar_in),
        .addr       (addr),
        .seq        (seq),
        .phase      (phase),
        .opcode     (opcode),
        .target     (target),
        .lbus_sel   (lbus_sel),
        .rbus_sel   (rbus_sel),
        .alu_op     (alu_op),
        .illegal_op (illegal_op),
        .pc         (pc)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;   // 100 MHz
    end

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            mismatch_count++;
            $display("Mismatch %s: got 0x%0h, expected 0x%0h (pc 0x%0h, count %0d, t %0t)",
                     name, actual, expected, pc_m, cnt_m, $time);
        end
    endtask

    // 4/4/1/1 split of the ten counts
    function automatic cpu_ctrl_pkg::phase_e phase_of(input int cnt);
        if (cnt <= `CPU_FETCH_LAST)
            return cpu_ctrl_pkg::ph_fetch;
        else if (cnt < `CPU_EXEC_FIRST)
            return cpu_ctrl_pkg::ph_decode;
        else if (cnt == `CPU_EXEC_FIRST)
            return cpu_ctrl_pkg::ph_exec;
        return cpu_ctrl_pkg::ph_idle;
    endfunction

    task automatic compare_outputs();
        logic [2:0] op;
        logic       spare_op;
        op       = ir_m[`CPU_OP_HI:`CPU_OP_LO];
        spare_op = (op == 3'd3) || (op == 3'd7);   // no instruction behind these
        check_value("seq", 32'(seq), 32'(1) << cnt_m);
        check_value("phase", 32'(phase), 32'(phase_of(cnt_m)));
        check_value("pc", 32'(pc), 32'(pc_m));
        check_value("opcode", 32'(opcode), 32'(op));
        check_value("target", 32'(target), 32'(ir_m[`CPU_TARG_HI:`CPU_TARG_LO]));
        check_value("lbus_sel", 32'(lbus_sel), 32'(ir_m[`CPU_LBUS_HI:`CPU_LBUS_LO]));
        check_value("rbus_sel", 32'(rbus_sel), 32'(ir_m[`CPU_RBUS_HI:`CPU_RBUS_LO]));
        check_value("alu_op", 32'(alu_op), 32'(ir_m[`CPU_ALUOP_HI:`CPU_ALUOP_LO]));
        if (cnt_m <= `CPU_FETCH_LAST) begin
            check_value("addr", 32'(addr), 32'(pc_m));        // pc owns the bus in fetch
            check_value("illegal_op", 32'(illegal_op), 32'(0));
        end else begin
            check_value("addr", 32'(addr), 32'(prog_exp[pc_m]));
            if (!ir_m[`CPU_MODE_BIT])
                check_value("addr_vs_mar", 32'(addr), 32'(mar_m)); // last loaded mar
            check_value("illegal_op", 32'(illegal_op), 32'(spare_op));
        end
    endtask

    task automatic finish_run();
        $display("mismatches: %0d, other errors: %0d", mismatch_count, other_errors);
        if (mismatch_count == 0 && other_errors == 0)
            $display("No errors");
        else
            $display("Errors found");
        $finish;
    endtask

    // synchronous rom, data follows addr by one cycle
    always @(posedge clk) begin
        rom_data <= rom[addr];
    end

    // mar load strobe high during count 1 with this instruction's value
    always @(posedge clk) begin
        if (rst_n && seq[0] && int'(pc) < n_instr) begin
            mar_load <= 1'b1;
            mar_in   <= prog_mar[pc];
        end else begin
            mar_load <= 1'b0;
        end
    end

    // compare, then step the model with the inputs sampled at this edge
    always @(posedge clk) begin
        if (model_valid)
            compare_outputs();
        if (!rst_n) begin
            cnt_m       = 0;
            pc_m        = '0;
            mar_m       = '0;
            ir_m        = '0;   // opcode 0, register mode
            model_valid = 1'b1;
        end else begin
            if (mar_load)
                mar_m = mar_in;
            if (cnt_m == `CPU_FETCH_LAST)
                ir_m = rom[pc_m];    // word at this instruction's pc
            if (cnt_m == `CPU_SEQ_LAST) begin
                pc_m  = pc_m + `CPU_ADDR_W'(1);
                cnt_m = 0;
                done_count++;
            end else begin
                cnt_m++;
            end
        end
    end

    initial begin
        logic [31:0] rnd;
        rst_n <= 1'b0;
        for (int i = 0; i < 3*max_golden; i++)
            golden_mem[i] = '1;   // mar never uses the top byte, so ones mark unused lines
        $readmemh("test/cpu_ctrl_golden.txt", golden_mem);
        n_golden = 0;
        while (n_golden < max_golden &&
               golden_mem[3*n_golden+1][`CPU_INSTR_W-1:`CPU_ADDR_W] == '0)
            n_golden++;
        if (n_golden == 0) begin
            other_errors++;
            $display("golden file test/cpu_ctrl_golden.txt is missing or holds no entries");
        end
        // whole-address fill so stray reads are recognizable
        for (int a = 0; a < mem_depth; a++) begin
            rom[a]      = {8'(a) ^ 8'h5a, `CPU_ADDR_W'(a)};
            prog_mar[a] = '0;
            prog_exp[a] = '0;
        end
        for (int i = 0; i < n_golden; i++) begin
            rom[i]      = golden_mem[3*i];
            prog_mar[i] = golden_mem[3*i+1][`CPU_ADDR_W-1:0];
            prog_exp[i] = golden_mem[3*i+2][`CPU_ADDR_W-1:0];
        end
        n_instr = n_golden + n_random;
        for (int i = n_golden; i < n_instr; i++) begin
            rnd         = $random(seed);
            rom[i]      = rnd[`CPU_INSTR_W-1:0];
            rnd         = $random(seed);
            prog_mar[i] = rnd[`CPU_ADDR_W-1:0];
            // direct mode puts the low word on the bus, register mode the mar
            if (rom[i][`CPU_MODE_BIT])
                prog_exp[i] = rom[i][`CPU_DIRECT_HI:`CPU_DIRECT_LO];
            else
                prog_exp[i] = prog_mar[i];
        end
        program_ready = 1'b1;
        repeat (reset_cycles) @(posedge clk);
        rst_n <= 1'b1;
        wait (done_count == n_instr);   // each instruction ends on its idle count
        finish_run();
    end

    // watchdog sized from the instruction count
    initial begin
        int limit;
        wait (program_ready);
        limit = reset_cycles + n_instr * `CPU_SEQ_W + 50;
        repeat (limit) @(posedge clk);
        other_errors++;
        $display("Timeout: run did not finish within %0d cycles", limit);
        finish_run();
    end

endmodule : cpu_ctrl_tb

/* verilog/address_selector.sv */
`timescale 1ns/1ps
`include "cpu_ctrl_macros.svh"

module address_selector (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   mar_load,            // strobe
    input  logic [`CPU_ADDR_W-1:0] mar_in,
    input  logic [`CPU_ADDR_W-1:0] pc,
    input  logic [`CPU_ADDR_W-1:0] direct_addr,         // ir[15:0]
    input  logic                   addrmode_pc_n,
    input  logic                   addrmode_register_n,
    input  logic                   addrmode_direct_n,
    output logic [`CPU_ADDR_W-1:0] addr,
    output logic [`CPU_ADDR_W-1:0] mar
);

    // memory address register, loadable at any edge
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mar <= '0;
        end else if (mar_load) begin
            mar <= mar_in;
        end
    end

    // the real bus is three tri-state drivers
    // here each source is gated by its own enable and the results or'ed
    assign addr = ({`CPU_ADDR_W{~addrmode_pc_n}}       & pc)   |
                  ({`CPU_ADDR_W{~addrmode_register_n}} & mar)  |
                  ({`CPU_ADDR_W{~addrmode_direct_n}}   & direct_addr);

    // bus is neither floating nor contended
    a_one_driver: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot(~{addrmode_pc_n, addrmode_register_n, addrmode_direct_n}));

endmodule : address_selector

/* verilog/cpu_ctrl_macros.svh */
`ifndef CPU_CTRL_MACROS_SVH
`define CPU_CTRL_MACROS_SVH

`define CPU_INSTR_W      24 // rom word width
`define CPU_ADDR_W       16 // address bus width
`define CPU_SEQ_W        10 // decade sequencer length
`define CPU_FETCH_LAST   3  // last fetch count
`define CPU_DECODE_FIRST 4
`define CPU_EXEC_FIRST   8
`define CPU_SEQ_LAST     9  // idle count

// instruction word fields
`define CPU_MODE_BIT  23 // 0 register, 1 direct
`define CPU_OP_HI     23
`define CPU_OP_LO     21
`define CPU_TARG_HI   20
`define CPU_TARG_LO   16
`define CPU_LBUS_HI   12
`define CPU_LBUS_LO   9
`define CPU_RBUS_HI   8
`define CPU_RBUS_LO   5
`define CPU_ALUOP_HI  4
`define CPU_ALUOP_LO  0
`define CPU_DIRECT_HI 15
`define CPU_DIRECT_LO 0

`endif

/* verilog/cpu_ctrl_pkg.sv */
package cpu_ctrl_pkg;

    // instruction opcodes from ir[23:21]
    // top bit doubles as the addressing mode, 0 register and 1 direct
    typedef enum logic [2:0] {
        op_dev_eq_alu      = 3'd0, // dev = lbus alu rbus
        op_dev_eq_const8   = 3'd1, // dev = 8-bit constant from rom
        op_devp_eq_const16 = 3'd2, // device pair = 16-bit constant
        op_unused3         = 3'd3, // spare slot in register mode
        op_dev_eq_rom_abs  = 3'd4, // dev = rom[direct]
        op_dev_eq_ram_abs  = 3'd5, // dev = ram[direct]
        op_ram_abs_eq_dev  = 3'd6, // ram[direct] = dev
        op_unused7         = 3'd7  // spare slot in direct mode
    } opcode_e;

    // instruction phases as seen on the top level
    typedef enum logic [1:0] {
        ph_fetch,  // counts 0..3
        ph_decode, // counts 4..7
        ph_exec,   // count 8
        ph_idle    // count 9
    } phase_e;

endpackage : cpu_ctrl_pkg

/* verilog/cpu_ctrl_top.sv */
`timescale 1ns/1ps
`include "cpu_ctrl_macros.svh"

module cpu_ctrl_top (
    input  logic                                   clk,
    input  logic                                   rst_n,
    input  logic [`CPU_INSTR_W-1:0]                rom_data,
    input  logic                                   mar_load,
    input  logic [`CPU_ADDR_W-1:0]                 mar_in,
    output logic [`CPU_ADDR_W-1:0]                 addr,     // to rom and ram
    output logic [`CPU_SEQ_W-1:0]                  seq,
    output cpu_ctrl_pkg::phase_e                   phase,
    output cpu_ctrl_pkg::opcode_e                  opcode,
    output logic [`CPU_TARG_HI-`CPU_TARG_LO:0]     target,
    output logic [`CPU_LBUS_HI-`CPU_LBUS_LO:0]     lbus_sel,
    output logic [`CPU_RBUS_HI-`CPU_RBUS_LO:0]     rbus_sel,
    output logic [`CPU_ALUOP_HI-`CPU_ALUOP_LO:0]   alu_op,
    output logic                                   illegal_op,
    output logic [`CPU_ADDR_W-1:0]                 pc
);

    logic                    addr_mode;           // ir mode bit
    logic                    addrmode_pc_n;
    logic                    addrmode_register_n;
    logic                    addrmode_direct_n;
    logic [`CPU_ADDR_W-1:0]  direct_addr;

    phaser phaser0 (
        .clk                 (clk),
        .rst_n               (rst_n),
        .addr_mode           (addr_mode),
        .seq                 (seq),
        .phase               (phase),
        .addrmode_pc_n       (addrmode_pc_n),
        .addrmode_register_n (addrmode_register_n),
        .addrmode_direct_n   (addrmode_direct_n)
    );

    instruction_register ir0 (
        .clk         (clk),
        .rst_n       (rst_n),
        .seq         (seq),
        .rom_data    (rom_data),
        .opcode      (opcode),
        .addr_mode   (addr_mode),
        .target      (target),
        .lbus_sel    (lbus_sel),
        .rbus_sel    (rbus_sel),
        .alu_op      (alu_op),
        .direct_addr (direct_addr),
        .illegal_op  (illegal_op)
    );

    program_counter pc0 (
        .clk   (clk),
        .rst_n (rst_n),
        .seq   (seq),
        .pc    (pc)
    );

    // mar stays internal, only its effect on addr is visible
    address_selector asel0 (
        .clk                 (clk),
        .rst_n               (rst_n),
        .mar_load            (mar_load),
        .mar_in              (mar_in),
        .pc                  (pc),
        .direct_addr         (direct_addr),
        .addrmode_pc_n       (addrmode_pc_n),
        .addrmode_register_n (addrmode_register_n),
        .addrmode_direct_n   (addrmode_direct_n),
        .addr                (addr),
        .mar                 ()
    );

endmodule : cpu_ctrl_top

/* verilog/instruction_register.sv */
`timescale 1ns/1ps
`include "cpu_ctrl_macros.svh"

module instruction_register (
    input  logic                                     clk,
    input  logic                                     rst_n,
    input  logic [`CPU_SEQ_W-1:0]                    seq,
    input  logic [`CPU_INSTR_W-1:0]                  rom_data,
    output cpu_ctrl_pkg::opcode_e                    opcode,
    output logic                                     addr_mode,  // back to phaser
    output logic [`CPU_TARG_HI-`CPU_TARG_LO:0]       target,
    output logic [`CPU_LBUS_HI-`CPU_LBUS_LO:0]       lbus_sel,
    output logic [`CPU_RBUS_HI-`CPU_RBUS_LO:0]       rbus_sel,
    output logic [`CPU_ALUOP_HI-`CPU_ALUOP_LO:0]     alu_op,
    output logic [`CPU_DIRECT_HI-`CPU_DIRECT_LO:0]   direct_addr,
    output logic                                     illegal_op
);

    logic [`CPU_INSTR_W-1:0] ir_q;
    logic                    post_fetch; // counts 4..9

    // whole word is captured at once so the rom address may move afterwards
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ir_q <= '0; // opcode 0, register mode
        end else if (seq[`CPU_FETCH_LAST]) begin
            ir_q <= rom_data;
        end
    end

    // field slicing
    assign opcode      = cpu_ctrl_pkg::opcode_e'(ir_q[`CPU_OP_HI:`CPU_OP_LO]);
    assign addr_mode   = ir_q[`CPU_MODE_BIT];
    assign target      = ir_q[`CPU_TARG_HI:`CPU_TARG_LO];
    assign lbus_sel    = ir_q[`CPU_LBUS_HI:`CPU_LBUS_LO];
    assign rbus_sel    = ir_q[`CPU_RBUS_HI:`CPU_RBUS_LO];
    assign alu_op      = ir_q[`CPU_ALUOP_HI:`CPU_ALUOP_LO];
    assign direct_addr = ir_q[`CPU_DIRECT_HI:`CPU_DIRECT_LO];

    assign post_fetch = |seq[`CPU_SEQ_LAST:`CPU_DECODE_FIRST];

    // spare opcodes only matter once the new word is in place
    always_comb begin
        illegal_op = 1'b0;
        if (post_fetch) begin
            illegal_op = (opcode == cpu_ctrl_pkg::op_unused3) ||
                         (opcode == cpu_ctrl_pkg::op_unused7);
        end
    end

    // word holds for the whole instruction apart from the load edge
    a_ir_stable: assert property (@(posedge clk) disable iff (!rst_n)
        ($past(rst_n) && !$past(seq[`CPU_FETCH_LAST])) |-> $stable(ir_q));

endmodule : instruction_register

/* verilog/phaser.sv */
`timescale 1ns/1ps
`include "cpu_ctrl_macros.svh"

module phaser (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   addr_mode,           // from ir, 0 register 1 direct
    output logic [`CPU_SEQ_W-1:0]  seq,                 // one-hot count
    output cpu_ctrl_pkg::phase_e   phase,
    output logic                   addrmode_pc_n,       // pc drives the bus
    output logic                   addrmode_register_n, // mar drives the bus
    output logic                   addrmode_direct_n    // ir[15:0] drives the bus
);

    logic fetch_n;  // active low so that reset clearing it means fetch
    logic decode_q;
    logic exec_q;

    // rotating one-hot decade counter
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            seq <= `CPU_SEQ_W'(1); // count 0
        end else begin
            seq <= {seq[`CPU_SEQ_W-2:0], seq[`CPU_SEQ_W-1]};
        end
    end

    // phase flags set and cleared one count early so they line up with seq
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            fetch_n  <= 1'b0;
            decode_q <= 1'b0;
            exec_q   <= 1'b0;
        end else begin
            if (seq[`CPU_SEQ_LAST])
                fetch_n <= 1'b0;                   // wrapping to count 0
            else if (seq[`CPU_DECODE_FIRST-1])
                fetch_n <= 1'b1;                   // fetch ends after count 3

            if (seq[`CPU_FETCH_LAST])
                decode_q <= 1'b1;
            else if (seq[`CPU_EXEC_FIRST-1])
                decode_q <= 1'b0;

            if (seq[`CPU_EXEC_FIRST-1])
                exec_q <= 1'b1;                    // single count execute
            else if (seq[`CPU_EXEC_FIRST])
                exec_q <= 1'b0;
        end
    end

    always_comb begin
        if (!fetch_n)
            phase = cpu_ctrl_pkg::ph_fetch;
        else if (decode_q)
            phase = cpu_ctrl_pkg::ph_decode;
        else if (exec_q)
            phase = cpu_ctrl_pkg::ph_exec;
        else
            phase = cpu_ctrl_pkg::ph_idle; // count 9
    end

    // bus enables, pc during fetch and the ir mode bit otherwise
    assign addrmode_pc_n       = fetch_n;
    assign addrmode_register_n = ~fetch_n | addr_mode;
    assign addrmode_direct_n   = ~fetch_n | ~addr_mode;

    // sequencer never loses or duplicates its token
    a_seq_onehot: assert property (@(posedge clk) disable iff (!rst_n) $onehot(seq));

    // never two drivers on the address bus, and pc owns it exactly on the fetch counts
    a_enable_excl: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0(~{addrmode_pc_n, addrmode_register_n, addrmode_direct_n}) &&
        (addrmode_pc_n == !(|seq[`CPU_FETCH_LAST:0])));

endmodule : phaser

/* verilog/program_counter.sv */
`timescale 1ns/1ps
`include "cpu_ctrl_macros.svh"

module program_counter (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic [`CPU_SEQ_W-1:0]  seq,
    output logic [`CPU_ADDR_W-1:0] pc   // fetch address
);

    // one step per instruction on the idle count, wraps at 16 bits
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc <= '0;
        end else if (seq[`CPU_SEQ_LAST]) begin
            pc <= pc + `CPU_ADDR_W'(1);
        end
    end

    // rom sees a steady address for all four fetch counts
    a_pc_stable: assert property (@(posedge clk) disable iff (!rst_n)
        (|seq[`CPU_FETCH_LAST:1]) |-> $stable(pc));

endmodule : program_counter
